//--- all.f
hw/alu_pkg.sv
hw/reg_slice.sv
hw/lfsr.sv
hw/multiplier.sv
hw/alu.sv
hw/alu_apb_regs.sv
hw/alu_apb_top.sv
testbench/alu_assertions.sv
testbench/alu_tb.sv

//--- Makefile
TOP = alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/alu_tb.sv
/* APB ALU testbench */

`timescale 1ns/1ps

module alu_tb
	import alu_pkg::*;
();
	logic clk;
	logic rst_n;
	logic [APB_AW-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [7:0] res;
	logic res_valid;

	int errors;
	int cycle = 0;
	int last_done;
	logic [31:0] rng_state;
	logic [DATA_W-1:0] model_lfsr;
	logic [7:0] got_q[$];
	int got_cyc[$];
	logic [7:0] exp_q[$];
	int exp_count[$];
	int exp_first[$];

	alu_apb_top alu_apb_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.res(res),
		.res_valid(res_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Result bytes with the cycle they were seen in
	always @(negedge clk) begin
		if (rst_n && res_valid) begin
			got_q.push_back(res);
			got_cyc.push_back(cycle);
		end
	end

	// Galois LFSR, one step per bit
	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], rng_state[0]};
			rng_state = rng_state[0] ? ((rng_state >> 1) ^ 32'h8020_0003) : (rng_state >> 1);
		end
		return v;
	endfunction

	// Fibonacci step with taps 64, 63, 61, 60
	function automatic logic [DATA_W-1:0] lfsr_next(input logic [DATA_W-1:0] v);
		return {v[62:0], v[63] ^ v[62] ^ v[60] ^ v[59]};
	endfunction

	function automatic logic [OPC_W-1:0] make_opcode(input logic [2:0] op, input logic [1:0] wc);
		logic [63:0] r;
		r = random_bits(3);
		return {wc, r[2:1], op, r[0]};
	endfunction

	task automatic bus_transfer(input logic wr, input logic [APB_AW-1:0] addr,
		input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata, output logic err);
		int waited;
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!pready && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (!pready) begin
			errors++;
			$display("APB transfer to offset %h timed out waiting for pready", addr);
		end
		rdata = prdata;
		err = pslverr;
		last_done = cycle + 1;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		logic [APB_DW-1:0] rd;
		logic err;
		bus_transfer(1'b1, addr, data, rd, err);
	endtask

	// Reference model, bytes low first
	task automatic expect_result(input logic [OPC_W-1:0] opc, input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y);
		logic [DATA_W-1:0] r;
		int n;
		int k;
		r = '0;
		n = 1 << opc[7:6];
		case (opc[3:1])
			3'd1: begin
				if (opc[4]) begin
					r = model_lfsr;
					model_lfsr = lfsr_next(model_lfsr);
				end else begin
					r = y;
				end
			end
			3'd2: begin
				case (opc[5:4])
					2'd0: r = x & y;
					2'd1: r = x | y;
					2'd2: r = x ^ y;
					default: r = ~(x ^ y);
				endcase
			end
			3'd3: r = x + y;
			3'd4: r = opc[5] ? 64'($signed(x) * $signed(y)) : x * y;
			default: n = 0;
		endcase
		for (k = 0; k < n; k++) begin
			exp_q.push_back(opc[4] ? r[8*(n-1-k) +: 8] : r[8*k +: 8]);
		end
		exp_count.push_back(n);
	endtask

	task automatic issue_op(input logic [OPC_W-1:0] opc);
		logic [DATA_W-1:0] x;
		logic [DATA_W-1:0] y;
		x = random_bits(64);
		y = random_bits(64);
		write_reg(REG_A_LO, x[31:0]);
		write_reg(REG_A_HI, x[63:32]);
		write_reg(REG_B_LO, y[31:0]);
		write_reg(REG_B_HI, y[63:32]);
		expect_result(opc, x, y);
		write_reg(REG_OPCODE, APB_DW'(opc));
		exp_first.push_back(last_done + ALU_LAT);
	endtask

	task automatic wait_idle();
		logic [APB_DW-1:0] st;
		logic err;
		int tries;
		st = 1;
		tries = 0;
		while (st[0] && tries < 100) begin
			bus_transfer(1'b0, REG_STATUS, '0, st, err);
			tries++;
		end
		if (st[0]) begin
			errors++;
			$display("Status busy did not clear in time");
		end
	endtask

	task automatic check_results();
		int idx;
		int n;
		int first;
		int k;
		wait_idle();
		if (got_q.size() != exp_q.size()) begin
			errors++;
			$display("Error res byte count got %h expected %h", got_q.size(), exp_q.size());
		end else begin
			idx = 0;
			while (exp_count.size() > 0) begin
				n = exp_count.pop_front();
				first = exp_first.pop_front();
				for (k = 0; k < n; k++) begin
					if (got_q[idx] !== exp_q[idx]) begin
						errors++;
						$display("Error res got %h expected %h", got_q[idx], exp_q[idx]);
					end
					if (got_cyc[idx] != first + k) begin
						errors++;
						$display("Error res_valid cycle got %h expected %h",
							got_cyc[idx], first + k);
					end
					idx++;
				end
			end
		end
		got_q.delete();
		got_cyc.delete();
		exp_q.delete();
		exp_count.delete();
		exp_first.delete();
	endtask

	initial begin
		int i;
		int first_done;
		logic [63:0] v;
		logic [APB_DW-1:0] rdata;
		logic err;
		logic [OPC_W-1:0] opc;
		errors = 0;
		rng_state = 32'd74306;
		model_lfsr = LFSR_SEED;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		if (res_valid !== 1'b0) begin
			errors++;
			$display("Error res_valid got %h expected %h", res_valid, 1'b0);
		end
		@(posedge clk);
		#1;
		bus_transfer(1'b0, REG_STATUS, '0, rdata, err);
		if (rdata !== '0) begin
			errors++;
			$display("Error status got %h expected %h", rdata, 32'h0);
		end

		// Operand readback and an unmapped offset
		for (i = 0; i < 4; i++) begin
			v = random_bits(32);
			write_reg(APB_AW'(4 * i), v[31:0]);
			bus_transfer(1'b0, APB_AW'(4 * i), '0, rdata, err);
			if (rdata !== v[31:0]) begin
				errors++;
				$display("Error prdata got %h expected %h", rdata, v[31:0]);
			end
		end
		bus_transfer(1'b0, 8'h18, '0, rdata, err);
		if (err !== 1'b1) begin
			errors++;
			$display("Error pslverr got %h expected %h", err, 1'b1);
		end

		for (i = 0; i < 24; i++) begin
			issue_op(make_opcode(i[0] ? OP_MUL : OP_ADD, i[2:1]));
			check_results();
		end
		for (i = 0; i < 16; i++) begin
			opc = make_opcode(OP_MASK, i[1:0]);
			opc[5:4] = i[3:2];
			issue_op(opc);
			check_results();
		end
		for (i = 0; i < 4; i++) begin
			opc = make_opcode(OP_SET, i[1:0]);
			opc[ORDER_BIT] = 1'b0;
			issue_op(opc);
			check_results();
		end
		// Random sets, one set from B in the middle
		for (i = 0; i < 8; i++) begin
			opc = make_opcode(OP_SET, 2'd3);
			opc[ORDER_BIT] = (i != 4);
			issue_op(opc);
			check_results();
		end
		for (i = 0; i < 8; i++) begin
			issue_op(make_opcode((i[1:0] == 2'd0) ? OP_NOP : {1'b1, i[1:0]}, i[2:1]));
			check_results();
		end

		// Second opcode arrives while the first result streams
		issue_op(make_opcode(OP_ADD, 2'd3));
		first_done = last_done;
		issue_op(make_opcode(OP_MUL, 2'd2));
		if (last_done < first_done + ALU_LAT + 8) begin
			errors++;
			$display("Second opcode write completed while the first result was still streaming");
		end
		check_results();

		$display("Finished with %0d errors", errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- testbench/alu_assertions.sv
/* APB and result stream checks */

`timescale 1ns/1ps

module alu_assertions
	import alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic pready,
	input logic res_valid
);
	logic opc_access;

	assign opc_access = psel && penable && pwrite && (paddr == REG_OPCODE);

	// Wait states belong to an access phase only
	assert property (@(posedge clk) disable iff (!rst_n) !(psel && penable) |-> pready)
		else $error("pready low outside an access phase");

	assert property (@(posedge clk) !rst_n |=> !res_valid)
		else $error("res_valid high during reset");

	// Stalled write is held, and not released while a result still streams
	assert property (@(posedge clk) disable iff (!rst_n)
		opc_access && !pready |=> opc_access && !(pready && res_valid))
		else $error("stalled opcode write released while a result was streaming");

endmodule

bind alu_apb_top alu_assertions alu_assertions_inst (
	.clk(clk),
	.rst_n(rst_n),
	.paddr(paddr),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.pready(pready),
	.res_valid(res_valid)
);

//--- hw/alu_apb_top.sv
/* ALU with APB front end */

`timescale 1ns/1ps

module alu_apb_top
	import alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_DW-1:0] pwdata,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [7:0] res,
	output logic res_valid
);
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [OPC_W-1:0] opcode;
	logic busy;

	alu_apb_regs regs_inst (
		.clk(clk),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.a(a),
		.b(b),
		.opcode(opcode)
	);

	alu alu_inst (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.a(a),
		.b(b),
		.res(res),
		.res_valid(res_valid),
		.busy(busy)
	);

endmodule

//--- hw/alu_apb_regs.sv
/* APB register block for the ALU */

`timescale 1ns/1ps

module alu_apb_regs
	import alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [APB_AW-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_DW-1:0] pwdata,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	output logic [DATA_W-1:0] a,
	output logic [DATA_W-1:0] b,
	output logic [OPC_W-1:0] opcode
);
	logic [APB_DW-1:0] a_lo;
	logic [APB_DW-1:0] a_hi;
	logic [APB_DW-1:0] b_lo;
	logic [APB_DW-1:0] b_hi;
	logic access;
	logic mapped;
	logic wr_fire;

	always_comb begin
		access = psel && penable;
		// Opcode writes wait out the running operation
		pready = !(access && pwrite && paddr == REG_OPCODE && busy);
		wr_fire = access && pwrite && pready;
		case (paddr)
			REG_A_LO, REG_A_HI, REG_B_LO, REG_B_HI, REG_OPCODE, REG_STATUS: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
		pslverr = access && !mapped;
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				REG_A_LO: prdata = a_lo;
				REG_A_HI: prdata = a_hi;
				REG_B_LO: prdata = b_lo;
				REG_B_HI: prdata = b_hi;
				REG_STATUS: prdata = APB_DW'(busy);
				default: prdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			case (paddr)
				REG_A_LO: a_lo <= pwdata;
				REG_A_HI: a_hi <= pwdata;
				REG_B_LO: b_lo <= pwdata;
				REG_B_HI: b_hi <= pwdata;
				default: ;
			endcase
		end
	end

	// One-cycle issue pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			opcode <= '0;
		end else if (wr_fire && paddr == REG_OPCODE) begin
			opcode <= pwdata[OPC_W-1:0];
		end else begin
			opcode <= '0;
		end
	end

	assign a = {a_hi, a_lo};
	assign b = {b_hi, b_lo};

endmodule

//--- hw/alu.sv
/* Pipelined ALU with byte serializer */

`timescale 1ns/1ps

module alu
	import alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [OPC_W-1:0] opcode,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	output logic [7:0] res,
	output logic res_valid,
	output logic busy
);
	typedef struct packed {
		logic [BYTES-1:0] mask;
		logic [DATA_W-1:0] data;
	} s3_t;

	logic [OP_W-1:0] op_in;
	logic [OP_W-1:0] src_s1;
	logic [OP_W-1:0] op_s3;
	logic issue;
	logic lfsr_en;
	logic [DATA_W-1:0] lfsr_value;
	logic [DATA_W-1:0] result_add;
	logic [DATA_W-1:0] result_set;
	logic [DATA_W-1:0] result_mask;
	logic [DATA_W-1:0] result_s2;
	logic [DATA_W-1:0] result_s2_s3;
	logic [DATA_W-1:0] result_mult;
	logic [DATA_W-1:0] sel_s3;
	logic [DATA_W-1:0] result_s3;
	logic [DATA_W-1:0] result_s4;
	logic [OPC_W-1:0] opcode_s3;
	logic [1:0] wc_s3;
	logic order_s3;
	logic [BYTES-1:0] mask_s3;
	logic [BYTES-1:0] mask_s4;
	s3_t s3_in;
	s3_t s3_out;
	logic inflight;
	logic nop_q;
	logic [LAT_CNT_W-1:0] cnt;

	function automatic logic is_real_op(input logic [OP_W-1:0] op);
		return (op >= OP_SET) && (op <= OP_MUL);
	endfunction

	function automatic logic [BYTES-1:0] width_mask(input logic [1:0] wc);
		case (wc)
			2'd0: return 8'b0000_0001;
			2'd1: return 8'b0000_0011;
			2'd2: return 8'b0000_1111;
			default: return 8'b1111_1111;
		endcase
	endfunction

	// Keep the low 2^wc bytes, optionally mirrored inside that width
	function automatic logic [DATA_W-1:0] trim_bytes(input logic [DATA_W-1:0] v,
		input logic [1:0] wc, input logic rev);
		logic [DATA_W-1:0] t;
		int n;
		t = '0;
		n = 1 << wc;
		for (int i = 0; i < BYTES; i++) begin
			if (i < n) begin
				t[8*i +: 8] = rev ? v[8*(n-1-i) +: 8] : v[8*i +: 8];
			end
		end
		return t;
	endfunction

	always_comb begin
		op_in = opcode[OP_LSB +: OP_W];
		issue = (opcode != '0);
		lfsr_en = (op_in == OP_SET) && opcode[ORDER_BIT];
	end

	// Stage 1
	always_ff @(posedge clk) begin
		result_add <= a + b;
		result_set <= opcode[ORDER_BIT] ? lfsr_value : b;
		case (opcode[MFN_LSB +: 2])
			MASK_AND: result_mask <= a & b;
			MASK_OR: result_mask <= a | b;
			MASK_XOR: result_mask <= a ^ b;
			default: result_mask <= a ~^ b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			src_s1 <= OP_NOP;
		end else begin
			src_s1 <= op_in;
		end
	end

	// Stage 2
	always_ff @(posedge clk) begin
		case (src_s1)
			OP_MASK: result_s2 <= result_mask;
			OP_ADD: result_s2 <= result_add;
			default: result_s2 <= result_set;
		endcase
	end

	// Stage 3
	always_comb begin
		op_s3 = opcode_s3[OP_LSB +: OP_W];
		wc_s3 = opcode_s3[WC_LSB +: 2];
		order_s3 = opcode_s3[ORDER_BIT];
		sel_s3 = (op_s3 == OP_MUL) ? result_mult : result_s2_s3;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mask_s3 <= '0;
		end else begin
			mask_s3 <= is_real_op(op_s3) ? width_mask(wc_s3) : '0;
		end
	end

	always_ff @(posedge clk) begin
		result_s3 <= trim_bytes(sel_s3, wc_s3, order_s3);
	end

	always_comb begin
		s3_in.mask = mask_s3;
		s3_in.data = result_s3;
	end

	// Stage 4, takes a new word only while on the last byte or idle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mask_s4 <= '0;
		end else if (mask_s4 <= BYTES'(1)) begin
			mask_s4 <= s3_out.mask;
		end else begin
			mask_s4 <= mask_s4 >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (mask_s4 <= BYTES'(1)) begin
			result_s4 <= s3_out.data;
		end else begin
			result_s4 <= result_s4 >> 8;
		end
	end

	assign res = result_s4[7:0];
	assign res_valid = mask_s4[0];

	// In-flight tracking for busy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			inflight <= 1'b0;
			nop_q <= 1'b0;
			cnt <= '0;
		end else if (issue) begin
			inflight <= 1'b1;
			nop_q <= !is_real_op(op_in);
			cnt <= LAT_CNT_W'(ALU_LAT);
		end else if (inflight) begin
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
			if ((nop_q && cnt == LAT_CNT_W'(1)) || (!nop_q && mask_s4 == BYTES'(1))) begin
				inflight <= 1'b0;
			end
		end
	end

	assign busy = inflight | issue;

	multiplier mult_inst (
		.clk(clk),
		.rst_n(rst_n),
		.is_signed(opcode[SIGNED_BIT]),
		.a(a),
		.b(b),
		.product(result_mult)
	);

	reg_slice #(.T(logic [OPC_W-1:0]), .DEPTH(MUL_LAT)) opcode_slice (
		.clk(clk),
		.rst_n(rst_n),
		.data_in(opcode),
		.data_out(opcode_s3)
	);

	reg_slice #(.T(logic [DATA_W-1:0]), .DEPTH(S2_DELAY)) result_slice (
		.clk(clk),
		.rst_n(rst_n),
		.data_in(result_s2),
		.data_out(result_s2_s3)
	);

	reg_slice #(.T(s3_t), .DEPTH(OUT_DELAY)) out_slice (
		.clk(clk),
		.rst_n(rst_n),
		.data_in(s3_in),
		.data_out(s3_out)
	);

	lfsr lfsr_inst (
		.clk(clk),
		.rst_n(rst_n),
		.enable(lfsr_en),
		.value(lfsr_value)
	);

endmodule

//--- hw/multiplier.sv
/* Pipelined 64x64 multiplier */

`timescale 1ns/1ps

module multiplier
	import alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic is_signed,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] product
);
	logic [DATA_W-1:0] a_q;
	logic [DATA_W-1:0] b_q;
	logic signed_q;
	logic signed [DATA_W:0] a_ext;
	logic signed [DATA_W:0] b_ext;
	logic [DATA_W-1:0] prod_lo;
	logic [DATA_W-1:0] pipe [MUL_LAT-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_q <= '0;
			b_q <= '0;
			signed_q <= 1'b0;
		end else begin
			a_q <= a;
			b_q <= b;
			signed_q <= is_signed;
		end
	end

	always_comb begin
		a_ext = {signed_q & a_q[DATA_W-1], a_q};
		b_ext = {signed_q & b_q[DATA_W-1], b_q};
		prod_lo = DATA_W'(a_ext * b_ext);
	end

	// Operand register counts as the first of MUL_LAT stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MUL_LAT - 1; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0] <= prod_lo;
			for (int i = 1; i < MUL_LAT - 1; i++) begin
				pipe[i] <= pipe[i - 1];
			end
		end
	end

	assign product = pipe[MUL_LAT - 2];

endmodule

//--- hw/lfsr.sv
/* Fibonacci LFSR */

`timescale 1ns/1ps

module lfsr
	import alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	output logic [DATA_W-1:0] value
);
	logic feedback;

	// XOR of the tapped bits shifts in at the bottom
	assign feedback = ^(value & LFSR_TAPS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			value <= LFSR_SEED;
		end else if (enable) begin
			value <= {value[DATA_W-2:0], feedback};
		end
	end

endmodule

//--- hw/reg_slice.sv
/* Register delay line */

`timescale 1ns/1ps

module reg_slice #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 1
) (
	input logic clk,
	input logic rst_n,
	input T data_in,
	output T data_out
);
	T stages [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= data_in;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	assign data_out = stages[DEPTH - 1];

endmodule

//--- hw/alu_pkg.sv
/* ALU shared constants */

package alu_pkg;

	localparam int DATA_W = 64;
	localparam int BYTES = DATA_W / 8;
	localparam int OPC_W = 8;
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Opcode field positions
	localparam int OP_LSB = 1;
	localparam int OP_W = 3;
	localparam int ORDER_BIT = 4;
	localparam int MFN_LSB = 4;
	localparam int SIGNED_BIT = 5;
	localparam int WC_LSB = 6;

	localparam logic [OP_W-1:0] OP_NOP = 3'd0;
	localparam logic [OP_W-1:0] OP_SET = 3'd1;
	localparam logic [OP_W-1:0] OP_MASK = 3'd2;
	localparam logic [OP_W-1:0] OP_ADD = 3'd3;
	localparam logic [OP_W-1:0] OP_MUL = 3'd4;

	localparam logic [1:0] MASK_AND = 2'd0;
	localparam logic [1:0] MASK_OR = 2'd1;
	localparam logic [1:0] MASK_XOR = 2'd2;
	localparam logic [1:0] MASK_XNOR = 2'd3;

	localparam int MUL_LAT = 5;
	localparam int S2_DELAY = 3;
	localparam int ALU_LAT = 10;
	// Stage 3 sits at MUL_LAT + 1, the rest is padding before the serializer
	localparam int OUT_DELAY = ALU_LAT - MUL_LAT - 2;
	localparam int LAT_CNT_W = $clog2(ALU_LAT + 1);

	// Taps 64, 63, 61, 60
	localparam logic [DATA_W-1:0] LFSR_TAPS = 64'hD800_0000_0000_0000;
	localparam logic [DATA_W-1:0] LFSR_SEED = 64'd74306;

	localparam logic [APB_AW-1:0] REG_A_LO = 8'h00;
	localparam logic [APB_AW-1:0] REG_A_HI = 8'h04;
	localparam logic [APB_AW-1:0] REG_B_LO = 8'h08;
	localparam logic [APB_AW-1:0] REG_B_HI = 8'h0C;
	localparam logic [APB_AW-1:0] REG_OPCODE = 8'h10;
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h14;

endpackage
